//--- source/dcb_cfg.svh
/*
 * Build constants for the motor-current data collection buffer.
 * Register bus address map, buffer size and the collect bit.
 * Include wherever a width or an address constant is needed.
 */

`ifndef DCB_CFG_SVH
`define DCB_CFG_SVH

// buffer geometry
`define DCB_BUF_DEPTH     1024      // entries in the capture memory
`define DCB_ADDR_W        10        // buffer address width

// address blocks in reg addr bits 15:12
`define DCB_BLK_MAIN      4'h0      // per-channel board registers
`define DCB_BLK_BUF       4'h7      // capture buffer readback

// offsets in reg addr bits 3:0
`define DCB_OFF_DAC_CTRL  4'h1      // dac control, channel in bits 7:4
`define DCB_OFF_STATUS    4'he      // capture status, channel field must be 0

`define DCB_COLLECT_BIT   30        // start/stop bit in dac write data

`endif

//--- source/dcb_pkg.sv
/*
 * Shared types of the data collection buffer.
 * Host command, buffer entry layout, memory write and status structs,
 * plus the host port decode classes. Imported by the RTL and the checker.
 */

`default_nettype none

`include "dcb_cfg.svh"

package dcb_pkg;

    // kind of a stored entry, top two bits of the word
    typedef enum logic [1:0] {
        ENTRY_CMD = 2'd0,   // commanded current
        ENTRY_FB  = 2'd1    // feedback sample
    } entry_kind_e;

    // decoded dac control write, valid for one cycle
    typedef struct packed {
        logic        valid;
        logic [3:0]  chan;      // from reg addr bits 7:4
        logic        collect;   // collect bit of the write data
        logic [15:0] current;   // commanded current
    } dac_cmd_t;

    // one 32-bit buffer word
    typedef struct packed {
        entry_kind_e             kind;
        logic [`DCB_ADDR_W-1:0] addr_field;  // zero in memory, live addr on readback
        logic [3:0]              chan;
        logic [15:0]             sample;
    } buf_entry_t;

    // one memory write
    typedef struct packed {
        logic                   wr;
        logic [`DCB_ADDR_W-1:0] addr;
        buf_entry_t             entry;
    } buf_wr_t;

    // session state seen by the host
    typedef struct packed {
        logic                   collecting;
        logic [3:0]             chan;
        logic [`DCB_ADDR_W-1:0] wr_addr;     // address of the last write
    } capture_status_t;

    // host port decode result
    typedef enum logic [1:0] {
        OP_NONE,        // ignored write or unmapped read
        OP_DAC,         // dac control write
        OP_STATUS_RD,   // status register read
        OP_BUF_RD       // buffer read
    } reg_op_e;

endpackage

`default_nettype wire

//--- source/capture_ram.sv
/*
 * Capture memory, 32 bits wide by the buffer depth.
 * One synchronous write port fed by the controller and one read port
 * for the host with a single cycle of read latency.
 */

`default_nettype none

`include "dcb_cfg.svh"

module capture_ram
    import dcb_pkg::*;
(
    input  logic                   clk,
    input  buf_wr_t                wr,      // write strobe, address and entry
    input  logic [`DCB_ADDR_W-1:0] raddr,   // host read address
    output logic [31:0]            rdata    // word at raddr, one cycle later
);

    logic [31:0] mem [`DCB_BUF_DEPTH];  // contents undefined after reset

    // write port
    always_ff @(posedge clk) begin
        if (wr.wr)
            mem[wr.addr] <= wr.entry;
    end

    // registered read port
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- source/data_capture_ctrl.sv
/*
 * Capture session control for one channel at a time.
 * A dac command with the collect bit starts a session, later commands for
 * that channel and rising edges of the feedback strobe are written as
 * entries at consecutive addresses. The memory write is registered.
 */

`default_nettype none

`include "dcb_cfg.svh"

module data_capture_ctrl
    import dcb_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  dac_cmd_t        cmd,        // decoded dac control write
    input  logic            cur_fb_wen, // feedback ready strobe
    input  logic [15:0]     cur_fb,     // feedback sample
    output logic [3:0]      chan,       // channel whose adc sample is wanted
    output buf_wr_t         wr,         // memory write
    output capture_status_t status      // session state for the host
);

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------
    logic                   collecting;     // session running
    logic [3:0]             chan_q;         // latched session channel
    logic                   wr_en;          // registered write strobe
    logic [`DCB_ADDR_W-1:0] wr_addr;        // address of the current write
    buf_entry_t             wr_entry;       // payload, no reset
    logic                   fb_last;        // strobe of last cycle
    logic                   fb_pend;        // sample waiting behind a command
    logic [15:0]            fb_hold;        // the waiting sample

    logic                   fb_trig;        // rising edge of the strobe
    logic                   cmd_start;      // start of a new session
    logic                   cmd_same;       // command on the session channel
    logic                   cmd_keep;       // command entry to be written
    logic                   fb_now;         // feedback entry this cycle
    logic [`DCB_ADDR_W-1:0] addr_next;      // wrapped next address

    // ------------------------------------------------------------
    // command and feedback qualification
    // ------------------------------------------------------------
    assign fb_trig   = cur_fb_wen & ~fb_last;
    assign cmd_start = cmd.valid & cmd.collect & ~collecting;
    assign cmd_same  = cmd.valid & collecting & (cmd.chan == chan_q);
    assign cmd_keep  = cmd_start | (cmd_same & cmd.collect);   // stop writes nothing

    // other-channel commands are dropped so feedback still gets through
    assign fb_now = collecting & fb_trig & ~cmd_start & ~cmd_same;

    assign addr_next = (wr_addr == `DCB_ADDR_W'(`DCB_BUF_DEPTH - 1)) ?
                       '0 : wr_addr + 1'b1;

    // ------------------------------------------------------------
    // control registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            collecting <= 1'b0;
            chan_q     <= 4'd1;
            wr_en      <= 1'b0;
            wr_addr    <= '0;
            fb_last    <= 1'b0;
            fb_pend    <= 1'b0;
        end else begin
            fb_last <= cur_fb_wen;
            wr_en   <= 1'b0;
            fb_pend <= 1'b0;
            if (cmd_start) begin
                collecting <= 1'b1;
                chan_q     <= cmd.chan;
                wr_addr    <= '0;           // session always starts at entry 0
                wr_en      <= 1'b1;
                fb_pend    <= fb_trig;      // coincident edge goes next cycle
            end else if (cmd_same) begin
                collecting <= cmd.collect;
                if (cmd.collect) begin
                    wr_en   <= 1'b1;
                    wr_addr <= addr_next;
                    fb_pend <= fb_trig;
                end
            end else if (fb_pend || fb_now) begin
                // no edge can follow a pending one, the strobe is still high
                wr_en   <= 1'b1;
                wr_addr <= addr_next;
            end
        end
    end

    // ------------------------------------------------------------
    // entry payload
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (cmd_keep && fb_trig)
            fb_hold <= cur_fb;              // sample held behind the command
        if (cmd_keep) begin
            wr_entry <= '{kind: ENTRY_CMD, addr_field: '0,
                          chan: cmd.chan, sample: cmd.current};
        end else if (fb_pend) begin
            wr_entry <= '{kind: ENTRY_FB, addr_field: '0,
                          chan: chan_q, sample: fb_hold};
        end else if (fb_now) begin
            wr_entry <= '{kind: ENTRY_FB, addr_field: '0,
                          chan: chan_q, sample: cur_fb};
        end
    end

    // outputs
    assign chan   = chan_q;
    assign wr     = '{wr: wr_en, addr: wr_addr, entry: wr_entry};
    assign status = '{collecting: collecting, chan: chan_q, wr_addr: wr_addr};

endmodule

`default_nettype wire

//--- source/host_reg_port.sv
/*
 * Register bus side of the data collection buffer.
 * Turns dac control writes into a registered command and answers reads
 * from the capture memory or the status register one cycle later.
 */

`default_nettype none

`include "dcb_cfg.svh"

module host_reg_port
    import dcb_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [15:0]            reg_waddr,
    input  logic [31:0]            reg_wdata,
    input  logic                   reg_wen,
    input  logic [15:0]            reg_raddr,
    output logic [31:0]            reg_rdata,   // valid one cycle after reg_raddr
    output dac_cmd_t               cmd,
    input  capture_status_t        status,
    output logic [`DCB_ADDR_W-1:0] ram_raddr,
    input  logic [31:0]            ram_rdata
);

    reg_op_e     wr_op;         // class of the current write
    reg_op_e     rd_op;         // class of the current read address
    reg_op_e     rd_op_q;       // read class, aligned with ram_rdata
    logic        cmd_valid;
    logic [3:0]  cmd_chan;
    logic        cmd_collect;
    logic [15:0] cmd_current;
    buf_entry_t  mem_word;      // memory word with live address
    logic [31:0] status_word;

    // ------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------
    always_comb begin
        wr_op = OP_NONE;        // other offsets are simply dropped
        if (reg_wen && reg_waddr[15:12] == `DCB_BLK_MAIN &&
            reg_waddr[3:0] == `DCB_OFF_DAC_CTRL)
            wr_op = OP_DAC;
    end

    always_comb begin
        rd_op = OP_NONE;
        if (reg_raddr[15:12] == `DCB_BLK_BUF)
            rd_op = OP_BUF_RD;
        else if (reg_raddr[15:12] == `DCB_BLK_MAIN && reg_raddr[11:4] == 8'h00 &&
                 reg_raddr[3:0] == `DCB_OFF_STATUS)
            rd_op = OP_STATUS_RD;
    end

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
            rd_op_q   <= OP_NONE;
        end else begin
            cmd_valid <= (wr_op == OP_DAC);     // one cycle per write
            rd_op_q   <= rd_op;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_op == OP_DAC) begin
            cmd_chan    <= reg_waddr[7:4];
            cmd_collect <= reg_wdata[`DCB_COLLECT_BIT];
            cmd_current <= reg_wdata[15:0];
        end
    end

    assign cmd = '{valid: cmd_valid, chan: cmd_chan, collect: cmd_collect,
                   current: cmd_current};

    // ------------------------------------------------------------
    // read data
    // ------------------------------------------------------------
    assign ram_raddr = reg_raddr[`DCB_ADDR_W-1:0];  // ram adds the cycle

    always_comb begin
        mem_word            = buf_entry_t'(ram_rdata);
        mem_word.addr_field = status.wr_addr;       // live write address
    end

    assign status_word = {status.collecting, 11'd0, status.chan,
                          {(16 - `DCB_ADDR_W){1'b0}}, status.wr_addr};

    always_comb begin
        case (rd_op_q)
            OP_BUF_RD:    reg_rdata = mem_word;
            OP_STATUS_RD: reg_rdata = status_word;
            default:      reg_rdata = 32'd0;        // unmapped
        endcase
    end

endmodule

`default_nettype wire

//--- source/dcb_top.sv
/*
 * Top level of the motor-current data collection buffer.
 * Host register port, capture controller and capture memory.
 * Connect to the register bus and the current feedback of one board.
 */

`default_nettype none

`include "dcb_cfg.svh"

module dcb_top
    import dcb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // register bus
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    input  logic [15:0] reg_raddr,
    output logic [31:0] reg_rdata,
    // current feedback
    input  logic        cur_fb_wen,     // sample ready strobe
    input  logic [15:0] cur_fb,
    output logic [3:0]  chan            // selected adc channel
);

    dac_cmd_t               cmd;
    buf_wr_t                buf_wr;
    capture_status_t        status;
    logic [`DCB_ADDR_W-1:0] ram_raddr;
    logic [31:0]            ram_rdata;

    host_reg_port u_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .cmd       (cmd),
        .status    (status),
        .ram_raddr (ram_raddr),
        .ram_rdata (ram_rdata)
    );

    data_capture_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cur_fb_wen (cur_fb_wen),
        .cur_fb     (cur_fb),
        .chan       (chan),
        .wr         (buf_wr),
        .status     (status)
    );

    capture_ram u_ram (
        .clk   (clk),
        .wr    (buf_wr),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- verification/dcb_checker.sv
/*
 * Concurrent assertions on the capture controller.
 * Bound into data_capture_ctrl from the testbench top.
 */

`default_nettype none

`include "dcb_cfg.svh"

module dcb_checker
    import dcb_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input dac_cmd_t        cmd,
    input logic [3:0]      chan,        // latched session channel
    input buf_wr_t         wr,
    input capture_status_t status
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned            fail_count = 0;   // read by the testbench at the end
    logic [`DCB_ADDR_W-1:0] last_addr;        // address of the previous write
    logic [`DCB_ADDR_W-1:0] step_addr;

    always_ff @(posedge clk) begin
        if (!rst_n)
            last_addr <= '0;
        else if (wr.wr)
            last_addr <= wr.addr;
    end

    assign step_addr = (last_addr == `DCB_ADDR_W'(`DCB_BUF_DEPTH - 1)) ?
                       '0 : last_addr + 1'b1;   // wraps at depth

    // ------------------------------------------------------------
    // properties
    // ------------------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk) !rst_n && $past(!rst_n) |-> !wr.wr)
        else begin fail_count++; $error("memory write while in reset"); end

    a_fb_chan: assert property (@(posedge clk) disable iff (!rst_n)
        wr.wr && wr.entry.kind == ENTRY_FB |-> wr.entry.chan == chan)
        else begin fail_count++; $error("feedback entry on wrong channel"); end

    // session start is the only write not following the last address
    a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
        wr.wr && $past(status.collecting) |-> wr.addr == step_addr)
        else begin fail_count++; $error("write address skipped"); end

    a_cmd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cmd.valid |=> !cmd.valid)
        else begin fail_count++; $error("command valid held two cycles"); end

endmodule

`default_nettype wire

//--- verification/dcb_tb.sv
/*
 * Testbench for the data collection buffer top level.
 * Drives the register bus and feedback strobe, keeps a reference model
 * of the capture memory and checks status and buffer readback.
 */

`default_nettype none

`include "dcb_cfg.svh"

module dcb_tb
    import dcb_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS      = 20;
    localparam int TEST_CYCLES = 10 + 200 + 200 + `DCB_BUF_DEPTH + 60;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 500) * CLK_NS;   // plus margin

    typedef struct packed {
        logic            is_status;
        buf_entry_t      word;
        capture_status_t st;
    } exp_rd_t;

    logic        clk, rst_n;
    logic [15:0] reg_waddr, reg_raddr, cur_fb;
    logic [31:0] reg_wdata, reg_rdata;
    logic        reg_wen, cur_fb_wen;
    logic [3:0]  chan;
    logic        rd_req;
    logic        rd_chk = 1'b0;     // read data valid this cycle

    // reference model
    buf_entry_t             m_mem [`DCB_BUF_DEPTH];
    logic                   m_written [`DCB_BUF_DEPTH];
    logic [`DCB_ADDR_W-1:0] m_addr;
    logic [3:0]             m_chan;
    logic                   m_coll;

    dac_cmd_t    cmd_pipe;          // last write, as the controller gets it
    logic        fb_prev;           // strobe level of the last cycle
    logic [15:0] lfsr;
    int          errors, checks, test_errs, ntests;
    exp_rd_t     exp_q [$];

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    dcb_top uut (
        .clk(clk), .rst_n(rst_n),
        .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .cur_fb_wen(cur_fb_wen), .cur_fb(cur_fb), .chan(chan)
    );

    bind data_capture_ctrl dcb_checker u_checker (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .chan(chan), .wr(wr), .status(status)
    );

    // ------------------------------------------------------------
    // lfsr and reference model
    // ------------------------------------------------------------
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);   // galois step
        end
        return r;
    endfunction

    function automatic void store_entry(input entry_kind_e kind, input logic [3:0] ch,
                                        input logic [15:0] smp, input logic advance);
        if (advance)
            m_addr = (m_addr == `DCB_ADDR_W'(`DCB_BUF_DEPTH - 1)) ? '0 : m_addr + 1'b1;
        m_mem[m_addr]     = '{kind: kind, addr_field: '0, chan: ch, sample: smp};
        m_written[m_addr] = 1'b1;
    endfunction

    // one controller cycle of session rules
    function automatic void apply_rules(input dac_cmd_t c, input logic fb_edge,
                                        input logic [15:0] fb);
        if (c.valid && !m_coll && c.collect) begin
            m_coll = 1'b1;                          // new session at entry 0
            m_chan = c.chan;
            m_addr = '0;
            store_entry(ENTRY_CMD, c.chan, c.current, 1'b0);
        end else if (c.valid && m_coll && c.chan == m_chan) begin
            m_coll = c.collect;                     // clear bit stops, no entry
            if (c.collect)
                store_entry(ENTRY_CMD, c.chan, c.current, 1'b1);
        end
        if (fb_edge && m_coll)
            store_entry(ENTRY_FB, m_chan, fb, 1'b1);    // lands behind a command
    endfunction

    function automatic buf_entry_t expected_word(input logic [`DCB_ADDR_W-1:0] a);
        buf_entry_t e;
        e            = m_mem[a];
        e.addr_field = m_addr;                      // live address on readback
        return e;
    endfunction

    function automatic capture_status_t expected_status();
        return '{collecting: m_coll, chan: m_chan, wr_addr: m_addr};
    endfunction

    function automatic logic [15:0] dac_addr(input logic [3:0] ch);
        return {`DCB_BLK_MAIN, 4'h0, ch, `DCB_OFF_DAC_CTRL};
    endfunction

    function automatic logic [31:0] dac_data(input logic collect, input logic [15:0] cur);
        return {1'b0, collect, 14'h0, cur};
    endfunction

    // ------------------------------------------------------------
    // compare tasks and compare process
    // ------------------------------------------------------------
    task automatic check_word(input buf_entry_t got, input buf_entry_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: read %h, expected %h (kind %0d chan %0d sample %h)",
                     $time, got, exp, exp.kind, exp.chan, exp.sample);
        end
    endtask

    task automatic check_status(input capture_status_t got, input capture_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: status coll %b chan %0d addr %0d, expected %b %0d %0d",
                     $time, got.collecting, got.chan, got.wr_addr,
                     exp.collecting, exp.chan, exp.wr_addr);
        end
    endtask

    task automatic check_chan(input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: chan output %0d, expected %0d", $time, got, exp);
        end
    endtask

    always @(posedge clk) rd_chk <= rd_req;     // one cycle read latency

    always @(negedge clk) begin : compare_reads
        exp_rd_t         e;
        capture_status_t got_s;
        if (rd_chk) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("read data came back with no expected value at %0d ns", $time);
            end else begin
                e = exp_q.pop_front();
                if (e.is_status) begin
                    got_s = '{collecting: reg_rdata[31], chan: reg_rdata[19:16],
                              wr_addr: reg_rdata[9:0]};
                    check_status(got_s, e.st);
                    check_chan(chan, e.st.chan);    // adc select pin follows the session
                    if ((reg_rdata & 32'h7FF0_FC00) != 0) begin
                        errors++;
                        $display("Fail at %0d ns: status read has unused bits set", $time);
                    end
                end else begin
                    check_word(buf_entry_t'(reg_rdata), e.word);
                end
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------
    task automatic drive_cycle(input logic wen, input logic [15:0] waddr,
                               input logic [31:0] wdata, input logic fb_wen,
                               input logic [15:0] fb, input logic rd,
                               input logic [15:0] raddr);
        @(posedge clk);
        reg_wen    <= wen;
        reg_waddr  <= waddr;
        reg_wdata  <= wdata;
        cur_fb_wen <= fb_wen;
        cur_fb     <= fb;
        rd_req     <= rd;
        reg_raddr  <= raddr;
        // controller acts on last cycle's write and this cycle's strobe
        apply_rules(cmd_pipe, fb_wen && !fb_prev, fb);
        fb_prev          = fb_wen;
        cmd_pipe.valid   = wen && waddr[15:12] == `DCB_BLK_MAIN &&
                           waddr[3:0] == `DCB_OFF_DAC_CTRL;
        cmd_pipe.chan    = waddr[7:4];
        cmd_pipe.collect = wdata[`DCB_COLLECT_BIT];
        cmd_pipe.current = wdata[15:0];
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, 16'h0, 32'h0, 1'b0, 16'h0, 1'b0, 16'h0);
    endtask

    task automatic dac_write(input logic [3:0] ch, input logic collect, input logic [15:0] cur);
        drive_cycle(1'b1, dac_addr(ch), dac_data(collect, cur), 1'b0, 16'h0, 1'b0, 16'h0);
        idle(1);                                // gap between dac writes
    endtask

    task automatic fb_pulse(input logic [15:0] smp);
        drive_cycle(1'b0, 16'h0, 32'h0, 1'b1, smp, 1'b0, 16'h0);
        idle(1);
    endtask

    task automatic read_word(input logic [`DCB_ADDR_W-1:0] a);
        exp_q.push_back('{is_status: 1'b0, word: expected_word(a), st: '0});
        drive_cycle(1'b0, 16'h0, 32'h0, 1'b0, 16'h0, 1'b1, {`DCB_BLK_BUF, 2'b00, a});
    endtask

    task automatic read_range(input int lo, input int hi);
        for (int a = lo; a <= hi; a++)
            read_word(`DCB_ADDR_W'(a));
    endtask

    task automatic read_status();
        exp_q.push_back('{is_status: 1'b1, word: '0, st: expected_status()});
        drive_cycle(1'b0, 16'h0, 32'h0, 1'b0, 16'h0, 1'b1,
                    {`DCB_BLK_MAIN, 8'h00, `DCB_OFF_STATUS});
    endtask

    task automatic read_zero(input logic [15:0] raddr);
        exp_q.push_back('{is_status: 1'b0, word: '0, st: '0});
        drive_cycle(1'b0, 16'h0, 32'h0, 1'b0, 16'h0, 1'b1, raddr);
    endtask

    task automatic end_test(input string name);
        idle(3);                                // last read reaches the compare
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d reads never returned in test %s", exp_q.size(), name);
            exp_q.delete();
        end
        ntests++;
        $display("test %0d %s %s", ntests, name, (errors == test_errs) ? "ok" : "FAILED");
        test_errs = errors;
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        logic        do_wr, wrote, coll, fbw;
        logic [3:0]  ch, off;
        logic [15:0] cur, smp;
        rst_n      = 1'b0;
        reg_wen    = 1'b0;
        reg_waddr  = '0;
        reg_wdata  = '0;
        reg_raddr  = '0;
        cur_fb_wen = 1'b0;
        cur_fb     = '0;
        rd_req     = 1'b0;
        lfsr       = 16'd2;                     // seed
        m_coll     = 1'b0;
        m_chan     = 4'd1;
        m_addr     = '0;
        fb_prev    = 1'b0;
        cmd_pipe   = '0;
        errors     = 0;
        checks     = 0;
        test_errs  = 0;
        ntests     = 0;
        for (int i = 0; i < `DCB_BUF_DEPTH; i++)
            m_written[i] = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // reset values and unmapped reads
        idle(2);
        read_status();
        read_zero(16'h3000);
        read_zero({`DCB_BLK_MAIN, 4'h0, 4'h2, `DCB_OFF_STATUS});   // status needs chan 0
        end_test("reset status");

        // session on channel 5
        dac_write(4'd5, 1'b1, 16'h1000);
        fb_pulse(16'h0101);
        fb_pulse(16'h0102);
        dac_write(4'd5, 1'b1, 16'h1001);
        fb_pulse(16'h0103);
        dac_write(4'd5, 1'b1, 16'h1002);
        idle(5);
        read_range(0, m_addr);
        read_status();
        end_test("session on channel 5");

        // ignored traffic, held strobe gives one edge only
        dac_write(4'd3, 1'b1, 16'hBAD0);
        drive_cycle(1'b1, {`DCB_BLK_MAIN, 4'h0, 4'd5, 4'h2}, 32'h4000_BAD1,
                    1'b0, 16'h0, 1'b0, 16'h0);
        drive_cycle(1'b1, {`DCB_BLK_BUF, 12'h005}, 32'h4000_BAD2, 1'b0, 16'h0, 1'b0, 16'h0);
        repeat (4) drive_cycle(1'b0, 16'h0, 32'h0, 1'b1, 16'h0202, 1'b0, 16'h0);
        idle(5);
        read_status();
        read_range(0, m_addr);
        end_test("ignored traffic");

        // feedback edge together with a command
        drive_cycle(1'b1, dac_addr(4'd5), dac_data(1'b1, 16'h2000), 1'b0, 16'h0, 1'b0, 16'h0);
        drive_cycle(1'b0, 16'h0, 32'h0, 1'b1, 16'h0404, 1'b0, 16'h0);
        idle(6);
        read_range(m_addr - 1, m_addr);
        read_status();
        end_test("coincident feedback");

        // stop, then restart on channel 9
        dac_write(4'd5, 1'b0, 16'h0);
        fb_pulse(16'h0505);
        fb_pulse(16'h0506);
        idle(5);
        read_status();
        dac_write(4'd9, 1'b1, 16'h3000);
        fb_pulse(16'h0909);
        idle(5);
        read_status();
        read_range(0, m_addr);
        end_test("stop and restart");

        // random session
        dac_write(4'd5, 1'b1, rand_bits(16));
        wrote = 1'b0;
        for (int i = 0; i < 200; i++) begin
            do_wr = !wrote && (rand_bits(2) == 0);
            ch    = rand_bits(1) ? 4'd5 : 4'(rand_bits(4));
            coll  = rand_bits(3) != 0;
            off   = (rand_bits(3) == 0) ? `DCB_OFF_STATUS : `DCB_OFF_DAC_CTRL;
            cur   = rand_bits(16);
            fbw   = rand_bits(1);
            smp   = rand_bits(16);
            drive_cycle(do_wr, {`DCB_BLK_MAIN, 4'h0, ch, off}, dac_data(coll, cur),
                        fbw, smp, 1'b0, 16'h0);
            wrote = do_wr;
        end
        idle(5);
        read_status();
        for (int a = 0; a < `DCB_BUF_DEPTH; a++) begin
            if (m_written[a])
                read_word(`DCB_ADDR_W'(a));
        end
        end_test("random session");

        errors += int'(uut.u_ctrl.u_checker.fail_count);    // assertion failures
        $display("tests %0d, checks %0d, errors %0d", ntests, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dcb.f
+incdir+source
source/dcb_pkg.sv
source/capture_ram.sv
source/data_capture_ctrl.sv
source/host_reg_port.sv
source/dcb_top.sv
verification/dcb_checker.sv
verification/dcb_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the data collection buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module dcb_tb -f dcb.f -o sim_dcb

# assertion failures are counted by the testbench, so let the run go on
./obj_dir/sim_dcb +verilator+error+limit+1000 | tee sim.log

if grep -q "Simulation passed" sim.log; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi
